// File: src/ahbPkg.sv
`default_nettype none

package ahbPkg;

  // Bus widths
  localparam int dataWidth = 32;
  localparam int addrWidth = 32;

  // HSIZE encodings, only single-beat sizes up to a word
  typedef enum logic [2:0] {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } hSizeT;

  // Address bit that selects the interrupt controller over memory
  localparam int intCtrlSel = 31;

  // Interrupt controller register offsets
  localparam logic [3:0] regPending = 4'h0;
  localparam logic [3:0] regEnable  = 4'h4;
  localparam logic [3:0] regFiqSel  = 4'h8;

  // Interrupt sources
  localparam int numIrq = 8;

endpackage

`default_nettype wire

// File: src/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
  parameter int memWords = 256
) (
  input  wire logic                           clk,
  input  wire logic                           we,
  input  wire logic [ahbPkg::addrWidth-1:0]   addr,
  input  wire ahbPkg::hSizeT                  size,
  input  wire logic [ahbPkg::dataWidth-1:0]   wData,
  output logic [ahbPkg::dataWidth-1:0]        rData
);

  localparam int numLanes = ahbPkg::dataWidth / 8;
  localparam int idxBits  = $clog2(memWords);

  logic [ahbPkg::dataWidth-1:0] mem [memWords];
  logic [idxBits-1:0]           wordIdx;
  logic [numLanes-1:0]          laneEn;

  // Word index, wraps at the memory depth
  assign wordIdx = addr[idxBits+1:2];

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (size)
      ahbPkg::sizeByte: laneEn = 4'b0001 << addr[1:0];
      ahbPkg::sizeHalf: laneEn = addr[1] ? 4'b1100 : 4'b0011;
      default:          laneEn = 4'b1111;
    endcase
  end

  // Lanes take their bytes from the same lanes of wData
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      for (int i = 0; i < numLanes; i++)
      begin
        if (laneEn[i])
          mem[wordIdx][8*i +: 8] <= wData[8*i +: 8];
      end
    end
  end

  assign rData = mem[wordIdx];

endmodule

`default_nettype wire

// File: src/intCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module intCtrl (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           we,
  input  wire logic [3:0]                     regAddr,
  input  wire logic [ahbPkg::dataWidth-1:0]   wData,
  input  wire logic [ahbPkg::numIrq-1:0]      intSrc,
  output logic [ahbPkg::dataWidth-1:0]        rData,
  output logic                                irq,
  output logic                                fiq
);

  logic [ahbPkg::numIrq-1:0] pending;
  logic [ahbPkg::numIrq-1:0] enable;
  logic [ahbPkg::numIrq-1:0] fiqSel;
  logic [ahbPkg::numIrq-1:0] clearMask;

  // Write-one-to-clear on the pending register
  assign clearMask = (we && regAddr == ahbPkg::regPending) ?
                     wData[ahbPkg::numIrq-1:0] : '0;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      pending <= '0;
      enable  <= '0;
      fiqSel  <= '0;
      irq     <= 1'b0;
      fiq     <= 1'b0;
    end
    else
    begin
      // A source still high wins over a clear
      pending <= (pending & ~clearMask) | intSrc;
      if (we && regAddr == ahbPkg::regEnable)
        enable <= wData[ahbPkg::numIrq-1:0];
      if (we && regAddr == ahbPkg::regFiqSel)
        fiqSel <= wData[ahbPkg::numIrq-1:0];
      // Outputs trail pending by one cycle
      irq <= |(pending & enable & ~fiqSel);
      fiq <= |(pending & enable & fiqSel);
    end
  end

  always_comb
  begin
    rData = '0;
    case (regAddr)
      ahbPkg::regPending: rData[ahbPkg::numIrq-1:0] = pending;
      ahbPkg::regEnable:  rData[ahbPkg::numIrq-1:0] = enable;
      ahbPkg::regFiqSel:  rData[ahbPkg::numIrq-1:0] = fiqSel;
      default:            rData = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/ahbLite.sv
`timescale 1ns/1ps
`default_nettype none

module ahbLite #(
  parameter int memWords = 256
) (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           HRequest,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddr,
  input  wire logic                           HWrite,
  input  wire ahbPkg::hSizeT                  HSize,
  input  wire logic [ahbPkg::dataWidth-1:0]   HWData,
  input  wire logic [ahbPkg::numIrq-1:0]      intSrc,
  output logic [ahbPkg::dataWidth-1:0]        HRData,
  output logic                                HReady,
  output logic                                irq,
  output logic                                fiq
);

  logic                          dataPhaseQ;
  logic                          writeQ;
  logic                          intSelQ;
  logic [ahbPkg::addrWidth-1:0]  addrQ;
  ahbPkg::hSizeT                 sizeQ;

  logic                          memWe;
  logic                          intWe;
  logic [ahbPkg::dataWidth-1:0]  memRData;
  logic [ahbPkg::dataWidth-1:0]  intRData;

  // Address phase register, control part
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      dataPhaseQ <= 1'b0;
      writeQ     <= 1'b0;
      intSelQ    <= 1'b0;
    end
    else
    begin
      dataPhaseQ <= HRequest;
      writeQ     <= HRequest & HWrite;
      intSelQ    <= HAddr[ahbPkg::intCtrlSel];
    end
  end

  // Address and size carried into the data phase
  always_ff @(posedge clk)
  begin
    addrQ <= HAddr;
    sizeQ <= HSize;
  end

  assign HReady = dataPhaseQ;

  assign memWe = dataPhaseQ & writeQ & ~intSelQ;
  assign intWe = dataPhaseQ & writeQ & intSelQ;

  dataMem #(
    .memWords(memWords)
  ) uDataMem (
    .clk  (clk),
    .we   (memWe),
    .addr (addrQ),
    .size (sizeQ),
    .wData(HWData),
    .rData(memRData)
  );

  intCtrl uIntCtrl (
    .clk    (clk),
    .rstN   (rstN),
    .we     (intWe),
    .regAddr(addrQ[3:0]),
    .wData  (HWData),
    .intSrc (intSrc),
    .rData  (intRData),
    .irq    (irq),
    .fiq    (fiq)
  );

  // Read data from the target selected in the address phase
  assign HRData = intSelQ ? intRData : memRData;

endmodule

`default_nettype wire

// File: src/ahbArbiter3Way.sv
`timescale 1ns/1ps
`default_nettype none

module ahbArbiter3Way (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           HRequestM,
  input  wire logic                           HRequestF,
  input  wire logic                           HRequestT,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrM,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrF,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrT,
  input  wire logic                           HWriteM,
  input  wire ahbPkg::hSizeT                  HSizeM,
  input  wire logic [ahbPkg::dataWidth-1:0]   HWDataM,
  input  wire logic                           HReady,
  output logic                                HReadyM,
  output logic                                HReadyF,
  output logic                                HReadyT,
  output logic                                HRequest,
  output logic [ahbPkg::addrWidth-1:0]        HAddr,
  output logic                                HWrite,
  output ahbPkg::hSizeT                       HSize,
  output logic [ahbPkg::dataWidth-1:0]        HWData
);

  logic grantM;
  logic grantF;
  logic grantT;

  // One-hot owner of the data phase, bit 0 is M, 1 is F, 2 is T
  logic [2:0] ownerQ;

  // Fixed priority M > F > T
  assign grantM = HRequestM;
  assign grantF = HRequestF & ~HRequestM;
  assign grantT = HRequestT & ~HRequestM & ~HRequestF;

  assign HRequest = HRequestM | HRequestF | HRequestT;

  // Address phase mux
  always_comb
  begin
    if (grantM)
    begin
      HAddr  = HAddrM;
      HWrite = HWriteM;
      HSize  = HSizeM;
    end
    else if (grantF)
    begin
      HAddr  = HAddrF;
      HWrite = 1'b0;
      HSize  = ahbPkg::sizeWord;
    end
    else
    begin
      // T, or idle bus when nobody asks
      HAddr  = grantT ? HAddrT : '0;
      HWrite = 1'b0;
      HSize  = ahbPkg::sizeWord;
    end
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      ownerQ <= 3'b000;
    else
      ownerQ <= {grantT, grantF, grantM};
  end

  // Only the data-phase owner sees ready
  assign HReadyM = HReady & ownerQ[0];
  assign HReadyF = HReady & ownerQ[1];
  assign HReadyT = HReady & ownerQ[2];

  // Only M writes, data arrives in its data phase
  assign HWData = ownerQ[0] ? HWDataM : '0;

endmodule

`default_nettype wire

// File: src/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
  parameter int memWords = 256
) (
  input  wire logic                           clk,
  input  wire logic                           rstN,
  input  wire logic                           HRequestM,
  input  wire logic                           HRequestF,
  input  wire logic                           HRequestT,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrM,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrF,
  input  wire logic [ahbPkg::addrWidth-1:0]   HAddrT,
  input  wire logic                           HWriteM,
  input  wire ahbPkg::hSizeT                  HSizeM,
  input  wire logic [ahbPkg::dataWidth-1:0]   HWDataM,
  input  wire logic [ahbPkg::numIrq-1:0]      intSrc,
  output logic                                HReadyM,
  output logic                                HReadyF,
  output logic                                HReadyT,
  output logic [ahbPkg::dataWidth-1:0]        HRData,
  output logic                                irq,
  output logic                                fiq
);

  logic                          HRequest;
  logic [ahbPkg::addrWidth-1:0]  HAddr;
  logic                          HWrite;
  ahbPkg::hSizeT                 HSize;
  logic [ahbPkg::dataWidth-1:0]  HWData;
  logic                          HReady;

  ahbArbiter3Way uArbiter (
    .clk      (clk),
    .rstN     (rstN),
    .HRequestM(HRequestM),
    .HRequestF(HRequestF),
    .HRequestT(HRequestT),
    .HAddrM   (HAddrM),
    .HAddrF   (HAddrF),
    .HAddrT   (HAddrT),
    .HWriteM  (HWriteM),
    .HSizeM   (HSizeM),
    .HWDataM  (HWDataM),
    .HReady   (HReady),
    .HReadyM  (HReadyM),
    .HReadyF  (HReadyF),
    .HReadyT  (HReadyT),
    .HRequest (HRequest),
    .HAddr    (HAddr),
    .HWrite   (HWrite),
    .HSize    (HSize),
    .HWData   (HWData)
  );

  // Read data is shared by all three masters
  ahbLite #(
    .memWords(memWords)
  ) uAhbLite (
    .clk     (clk),
    .rstN    (rstN),
    .HRequest(HRequest),
    .HAddr   (HAddr),
    .HWrite  (HWrite),
    .HSize   (HSize),
    .HWData  (HWData),
    .intSrc  (intSrc),
    .HRData  (HRData),
    .HReady  (HReady),
    .irq     (irq),
    .fiq     (fiq)
  );

endmodule

`default_nettype wire

// File: test/tbMemSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tbMemSubsystem;

  localparam int memWords  = 256;
  localparam int clkPeriod = 4;
  localparam int numWords  = 8;
  localparam int numMerges = 8;
  // Word writes and reads, merge writes and reads, arbitration, two interrupt rounds
  localparam int numTransfers = 2 * numWords + 2 * numMerges + 4 + 14;

  logic                               clk = 1'b0;
  logic                               rstN;
  logic                               HRequestM;
  logic                               HRequestF;
  logic                               HRequestT;
  logic [ahbPkg::addrWidth-1:0]       HAddrM;
  logic [ahbPkg::addrWidth-1:0]       HAddrF;
  logic [ahbPkg::addrWidth-1:0]       HAddrT;
  logic                               HWriteM;
  ahbPkg::hSizeT                      HSizeM;
  logic [ahbPkg::dataWidth-1:0]       HWDataM;
  logic [ahbPkg::numIrq-1:0]          intSrc;
  logic                               HReadyM;
  logic                               HReadyF;
  logic                               HReadyT;
  logic [ahbPkg::dataWidth-1:0]       HRData;
  logic                               irq;
  logic                               fiq;

  // Shadow of the data memory and the word addresses written so far
  logic [31:0] shadow [memWords];
  logic [31:0] wordAddr [numWords];
  logic [31:0] seed = 32'he65f4f8a;

  always #(clkPeriod / 2) clk = ~clk;

  memSubsystem #(
    .memWords(memWords)
  ) uut (
    .clk      (clk),
    .rstN     (rstN),
    .HRequestM(HRequestM),
    .HRequestF(HRequestF),
    .HRequestT(HRequestT),
    .HAddrM   (HAddrM),
    .HAddrF   (HAddrF),
    .HAddrT   (HAddrT),
    .HWriteM  (HWriteM),
    .HSizeM   (HSizeM),
    .HWDataM  (HWDataM),
    .intSrc   (intSrc),
    .HReadyM  (HReadyM),
    .HReadyF  (HReadyF),
    .HReadyT  (HReadyT),
    .HRData   (HRData),
    .irq      (irq),
    .fiq      (fiq)
  );

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
      stopOnError($sformatf("Error %s expected %h actual %h", name, exp, act));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] intAddr(input logic [3:0] offset);
    logic [31:0] a;
    a = '0;
    a[ahbPkg::intCtrlSel] = 1'b1;
    a[3:0] = offset;
    return a;
  endfunction

  // Lane rule applied to the shadow word
  task automatic shadowWrite(input logic [31:0] addr, input ahbPkg::hSizeT size,
                             input logic [31:0] data);
    for (int i = 0; i < 4; i++)
    begin
      if (size == ahbPkg::sizeWord ||
          (size == ahbPkg::sizeHalf && addr[1] == (i >= 2)) ||
          (size == ahbPkg::sizeByte && addr[1:0] == 2'(i)))
        shadow[addr[9:2]][8*i +: 8] = data[8*i +: 8];
    end
  endtask

  // Address phase now, write data in the ready cycle
  task automatic writeM(input logic [31:0] addr, input ahbPkg::hSizeT size,
                        input logic [31:0] data);
    HRequestM = 1'b1;
    HAddrM    = addr;
    HWriteM   = 1'b1;
    HSizeM    = size;
    @(posedge clk);
    #1;
    checkEq("write ready", 32'd1, {31'd0, HReadyM});
    HRequestM = 1'b0;
    HWriteM   = 1'b0;
    HWDataM   = data;
  endtask

  task automatic readM(input logic [31:0] addr, input logic [31:0] exp, input string name);
    HRequestM = 1'b1;
    HAddrM    = addr;
    HWriteM   = 1'b0;
    HSizeM    = ahbPkg::sizeWord;
    @(posedge clk);
    #1;
    HRequestM = 1'b0;
    checkEq({name, " ready"}, 32'd1, {31'd0, HReadyM});
    checkEq(name, exp, HRData);
  endtask

  // Grant rule, the winner of a cycle owns the next one
  assert property (@(posedge clk) disable iff (!rstN) HRequestM |=> HReadyM)
  else
    stopOnError("Master M did not get ready one cycle after its request");
  assert property (@(posedge clk) disable iff (!rstN) (HRequestF && !HRequestM) |=> HReadyF)
  else
    stopOnError("Master F did not get ready one cycle after winning the bus");
  assert property (@(posedge clk) disable iff (!rstN)
                   (HRequestT && !HRequestM && !HRequestF) |=> HReadyT)
  else
    stopOnError("Master T did not get ready one cycle after winning the bus");
  assert property (@(posedge clk) disable iff (!rstN)
                   !(HRequestM || HRequestF || HRequestT) |=> !(HReadyM || HReadyF || HReadyT))
  else
    stopOnError("A ready was raised without any request in the previous cycle");
  assert property (@(posedge clk) $onehot0({HReadyM, HReadyF, HReadyT}))
  else
    stopOnError("More than one master saw ready in the same cycle");

  initial
  begin
    logic [31:0]   addr;
    logic [31:0]   en;
    logic [31:0]   fs;
    logic [31:0]   pend;
    ahbPkg::hSizeT size;
    int            b;
    rstN      = 1'b0;
    HRequestM = 1'b0;
    HRequestF = 1'b0;
    HRequestT = 1'b0;
    HAddrM    = '0;
    HAddrF    = '0;
    HAddrT    = '0;
    HWriteM   = 1'b0;
    HSizeM    = ahbPkg::sizeWord;
    HWDataM   = '0;
    intSrc    = '0;
    repeat (3)
    begin
      @(posedge clk);
      #1;
      checkEq("reset", 32'd0, {27'd0, HReadyM, HReadyF, HReadyT, irq, fiq});
    end
    rstN = 1'b1;
    @(posedge clk);
    #1;
    checkEq("after reset", 32'd0, {27'd0, HReadyM, HReadyF, HReadyT, irq, fiq});

    // Random word writes, upper address bits exercise the wrap
    for (int i = 0; i < numWords; i++)
    begin
      seed = xorshift(seed);
      addr = {1'b0, seed[30:2], 2'b00};
      seed = xorshift(seed);
      wordAddr[i] = addr;
      writeM(addr, ahbPkg::sizeWord, seed);
      shadowWrite(addr, ahbPkg::sizeWord, seed);
    end
    for (int i = 0; i < numWords; i++)
      readM(wordAddr[i], shadow[wordAddr[i][9:2]], "word read");

    // Byte and halfword merges into written words
    for (int i = 0; i < numMerges; i++)
    begin
      seed = xorshift(seed);
      addr = wordAddr[seed[2:0]] | {30'd0, seed[4:3]};
      size = seed[5] ? ahbPkg::sizeHalf : ahbPkg::sizeByte;
      if (size == ahbPkg::sizeHalf)
        addr[0] = 1'b0;
      seed = xorshift(seed);
      writeM(addr, size, seed);
      shadowWrite(addr, size, seed);
      readM({addr[31:2], 2'b00}, shadow[addr[9:2]], "merged read");
    end

    // All three ask at once, M keeps asking for a second transfer
    HRequestM = 1'b1;
    HAddrM    = wordAddr[0];
    HRequestF = 1'b1;
    HAddrF    = wordAddr[1];
    HRequestT = 1'b1;
    HAddrT    = wordAddr[2];
    @(posedge clk);
    #1;
    checkEq("arbitration M first", 32'd1, {29'd0, HReadyT, HReadyF, HReadyM});
    checkEq("arbitration M first data", shadow[wordAddr[0][9:2]], HRData);
    HAddrM = wordAddr[3];
    @(posedge clk);
    #1;
    HRequestM = 1'b0;
    checkEq("arbitration M back-to-back", 32'd1, {29'd0, HReadyT, HReadyF, HReadyM});
    checkEq("arbitration M second data", shadow[wordAddr[3][9:2]], HRData);
    @(posedge clk);
    #1;
    HRequestF = 1'b0;
    checkEq("arbitration F", 32'd2, {29'd0, HReadyT, HReadyF, HReadyM});
    checkEq("arbitration F data", shadow[wordAddr[1][9:2]], HRData);
    @(posedge clk);
    #1;
    HRequestT = 1'b0;
    checkEq("arbitration T", 32'd4, {29'd0, HReadyT, HReadyF, HReadyM});
    checkEq("arbitration T data", shadow[wordAddr[2][9:2]], HRData);

    // Round 0 routes the source to irq, round 1 to fiq
    for (int r = 0; r < 2; r++)
    begin
      seed = xorshift(seed);
      b    = int'(seed[2:0]);
      pend = 32'd1 << b;
      en   = {24'd0, seed[15:8]} | pend;
      fs   = {24'd0, seed[23:16]};
      fs[b] = r[0];
      writeM(intAddr(ahbPkg::regEnable), ahbPkg::sizeWord, en);
      writeM(intAddr(ahbPkg::regFiqSel), ahbPkg::sizeWord, fs);
      readM(intAddr(ahbPkg::regEnable), en, "enable readback");
      readM(intAddr(ahbPkg::regFiqSel), fs, "fiq select readback");
      intSrc[b] = 1'b1;
      @(posedge clk);
      #1;
      intSrc = '0;
      // Pending is set, the outputs follow one cycle later
      @(posedge clk);
      #1;
      checkEq("irq routing", r[0] ? 32'd0 : 32'd1, {31'd0, irq});
      checkEq("fiq routing", r[0] ? 32'd1 : 32'd0, {31'd0, fiq});
      readM(intAddr(ahbPkg::regPending), pend, "pending read");
      writeM(intAddr(ahbPkg::regPending), ahbPkg::sizeWord, pend);
      readM(intAddr(ahbPkg::regPending), 32'd0, "pending cleared");
      // The outputs drop one cycle after pending
      @(posedge clk);
      #1;
      checkEq("interrupt cleared", 32'd0, {30'd0, irq, fiq});
    end

    @(posedge clk);
    #1;
    $display("TEST OK");
    $finish;
  end

  initial
  begin
    #(numTransfers * 10 * clkPeriod);
    stopOnError("Watchdog timeout before all tests finished");
  end

endmodule

`default_nettype wire

// File: filelist.f
src/ahbPkg.sv
src/dataMem.sv
src/intCtrl.sv
src/ahbLite.sv
src/ahbArbiter3Way.sv
src/memSubsystem.sv
test/tbMemSubsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tbMemSubsystem
FILELIST  := filelist.f
BUILD     := obj_dir
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the simulation prints the pass line
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD)
